/* run.sh */
#!/usr/bin/env bash
# build and run the testbench, pass only if the pass line shows up
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -j 0 --top-module valu_tb -f valu.f -o valu_sim &&
./obj_dir/valu_sim | tee /dev/stderr | grep -qF "=== PASS ===" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }

/* tb/valu_clkgen.sv */
`timescale 1ns/1ps
`default_nettype none

module valu_clkgen #(
    parameter real PERIOD_NS  = 4.0,
    parameter int  RST_CYCLES = 4
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2.0) clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (RST_CYCLES) @(posedge clk);
        #1;
        rst = 1'b0; // released off the edge like other inputs
    end

endmodule

`default_nettype wire

/* tb/valu_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module valu_tb;

    localparam int DATA_W     = 64;
    localparam int ADDR_W     = 32;
    localparam int VL_W       = 8;
    localparam int MAX_CYCLES = 2000;

    typedef struct {
        int                cyc; // cycle the response must show up in
        logic [DATA_W-1:0] data;
        logic [7:0]        be;
        logic [ADDR_W-1:0] addr;
        logic [VL_W-1:0]   vl;
        logic              s;
        logic              e;
    } resp_t;

    logic                        clk;
    logic                        rst;
    logic                        req_valid;
    logic [valu_pkg::MNR_W-1:0]  req_op_mnr;
    logic [valu_pkg::FUNC_W-1:0] req_func_id;
    valu_pkg::sew_e              req_sew;
    logic [DATA_W-1:0]           req_data0;
    logic [DATA_W-1:0]           req_data1;
    logic [ADDR_W-1:0]           req_addr;
    logic [DATA_W/8-1:0]         req_be;
    logic [VL_W-1:0]             req_vl;
    logic                        req_start;
    logic                        req_end;
    logic                        req_mask;
    logic                        resp_valid;
    logic                        resp_start;
    logic                        resp_end;
    logic [DATA_W-1:0]           resp_data;
    logic [ADDR_W-1:0]           resp_addr;
    logic [DATA_W/8-1:0]         resp_be;
    logic [VL_W-1:0]             resp_vl;

    resp_t       exp_q[$];
    int          cyc = 0;
    int unsigned lcg_state = 94980;

    valu_clkgen #(.PERIOD_NS(4.0), .RST_CYCLES(4)) u_clkgen (.clk(clk), .rst(rst));

    valu_top #(
        .DATA_W (DATA_W),
        .ADDR_W (ADDR_W),
        .VL_W   (VL_W)
    ) u_dut (
        .clk         (clk),
        .rst         (rst),
        .req_valid   (req_valid),
        .req_op_mnr  (req_op_mnr),
        .req_func_id (req_func_id),
        .req_sew     (req_sew),
        .req_data0   (req_data0),
        .req_data1   (req_data1),
        .req_addr    (req_addr),
        .req_be      (req_be),
        .req_vl      (req_vl),
        .req_start   (req_start),
        .req_end     (req_end),
        .req_mask    (req_mask),
        .resp_valid  (resp_valid),
        .resp_start  (resp_start),
        .resp_end    (resp_end),
        .resp_data   (resp_data),
        .resp_addr   (resp_addr),
        .resp_be     (resp_be),
        .resp_vl     (resp_vl)
    );

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    function automatic logic [DATA_W-1:0] rand64();
        return {lcg_next(), lcg_next()};
    endfunction

    task automatic abort(input string why);
        $display("%s", why);
        $display("=== FAIL ===");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_data(input logic [DATA_W-1:0] got, input logic [DATA_W-1:0] exp);
        if (got !== exp) begin
            abort($sformatf("Fail %0t: resp_data got %h expected %h", $time, got, exp));
        end
    endtask

    task automatic check_be(input logic [DATA_W/8-1:0] got, input logic [DATA_W/8-1:0] exp);
        if (got !== exp) begin
            abort($sformatf("Fail %0t: resp_be got %h expected %h", $time, got, exp));
        end
    endtask

    task automatic check_flags(input logic got_s, input logic got_e,
                               input logic exp_s, input logic exp_e, input string what);
        if (got_s !== exp_s || got_e !== exp_e) begin
            abort($sformatf("Fail %0t: %s start/end got %b%b expected %b%b",
                            $time, what, got_s, got_e, exp_s, exp_e));
        end
    endtask

    task automatic check_tag(input logic [ADDR_W-1:0] got_addr, input logic [VL_W-1:0] got_vl,
                             input logic [ADDR_W-1:0] exp_addr, input logic [VL_W-1:0] exp_vl);
        if (got_addr !== exp_addr || got_vl !== exp_vl) begin
            abort($sformatf("Fail %0t: addr/vl got %h/%h expected %h/%h",
                            $time, got_addr, got_vl, exp_addr, exp_vl));
        end
    endtask

    // opcode encoding as listed for the request bus
    function automatic logic [5:0] func_of(valu_pkg::valu_op_e op);
        case (op)
            valu_pkg::OP_ADD, valu_pkg::OP_REDSUM:   return 6'b000000;
            valu_pkg::OP_REDAND:                     return 6'b000001;
            valu_pkg::OP_SUB, valu_pkg::OP_REDOR:    return 6'b000010;
            valu_pkg::OP_REDXOR:                     return 6'b000011;
            valu_pkg::OP_MINU, valu_pkg::OP_REDMINU: return 6'b000100;
            valu_pkg::OP_MIN, valu_pkg::OP_REDMIN:   return 6'b000101;
            valu_pkg::OP_MAXU, valu_pkg::OP_REDMAXU: return 6'b000110;
            valu_pkg::OP_MAX, valu_pkg::OP_REDMAX:   return 6'b000111;
            valu_pkg::OP_AND:                        return 6'b001001;
            valu_pkg::OP_OR:                         return 6'b001010;
            valu_pkg::OP_XOR:                        return 6'b001011;
            default:                                 return 6'b010111; // merge and move
        endcase
    endfunction

    function automatic logic [DATA_W-1:0] width_mask(int ew);
        return (ew == DATA_W) ? '1 : ((DATA_W'(1) << ew) - 1);
    endfunction

    function automatic longint sx(logic [DATA_W-1:0] v, int ew);
        return (ew == DATA_W || !v[ew-1]) ? longint'(v) : longint'(v | ~width_mask(ew));
    endfunction

    // one element step, a and b already masked to ew
    function automatic logic [DATA_W-1:0] fold(valu_pkg::valu_op_e op, int ew,
                                               logic [DATA_W-1:0] a, logic [DATA_W-1:0] b);
        logic [DATA_W-1:0] r;
        case (op)
            valu_pkg::OP_ADD, valu_pkg::OP_REDSUM:   r = a + b;
            valu_pkg::OP_SUB:                        r = a - b;
            valu_pkg::OP_AND, valu_pkg::OP_REDAND:   r = a & b;
            valu_pkg::OP_OR, valu_pkg::OP_REDOR:     r = a | b;
            valu_pkg::OP_XOR, valu_pkg::OP_REDXOR:   r = a ^ b;
            valu_pkg::OP_MINU, valu_pkg::OP_REDMINU: r = (a < b) ? a : b;
            valu_pkg::OP_MAXU, valu_pkg::OP_REDMAXU: r = (a > b) ? a : b;
            valu_pkg::OP_MIN, valu_pkg::OP_REDMIN:   r = (sx(a, ew) < sx(b, ew)) ? a : b;
            valu_pkg::OP_MAX, valu_pkg::OP_REDMAX:   r = (sx(a, ew) > sx(b, ew)) ? a : b;
            default:                                 r = '0;
        endcase
        return r & width_mask(ew);
    endfunction

    function automatic logic [DATA_W-1:0] elem_model(valu_pkg::valu_op_e op, valu_pkg::sew_e sew,
                                                     logic [DATA_W-1:0] d0, logic [DATA_W-1:0] d1,
                                                     logic [7:0] be);
        int ew;
        logic [DATA_W-1:0] m;
        logic [DATA_W-1:0] r;
        ew = 8 << int'(sew);
        m  = width_mask(ew);
        r  = '0;
        if (op == valu_pkg::OP_MERGE) begin
            for (int i = 0; i < DATA_W / 8; i++) begin
                r[i*8 +: 8] = be[i] ? d1[i*8 +: 8] : d0[i*8 +: 8];
            end
        end else if (op == valu_pkg::OP_MOVE) begin
            r = d0;
        end else begin
            for (int l = 0; l < DATA_W / ew; l++) begin
                r |= fold(op, ew, (d0 >> (l * ew)) & m, (d1 >> (l * ew)) & m) << (l * ew);
            end
        end
        return r;
    endfunction

    function automatic logic [DATA_W-1:0] replicate(logic [DATA_W-1:0] el, int ew);
        logic [DATA_W-1:0] r;
        r = '0;
        for (int l = 0; l < DATA_W / ew; l++) begin
            r |= el << (l * ew);
        end
        return r;
    endfunction

    task automatic drive(
        input logic [5:0]        func,
        input logic [2:0]        mnr,
        input logic              mask,
        input valu_pkg::sew_e    sew,
        input logic [DATA_W-1:0] d0,
        input logic [DATA_W-1:0] d1,
        input logic [7:0]        be,
        input logic [ADDR_W-1:0] addr,
        input logic [VL_W-1:0]   vl,
        input logic              s,
        input logic              e
    );
        @(posedge clk);
        #1;
        req_valid   = 1'b1;
        req_func_id = func;
        req_op_mnr  = mnr;
        req_mask    = mask;
        req_sew     = sew;
        req_data0   = d0;
        req_data1   = d1;
        req_be      = be;
        req_addr    = addr;
        req_vl      = vl;
        req_start   = s;
        req_end     = e;
    endtask

    task automatic idle_beat();
        @(posedge clk);
        #1;
        req_valid = 1'b0;
    endtask

    task automatic end_burst();
        idle_beat();
        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
    endtask

    task automatic send_elem(valu_pkg::valu_op_e op, valu_pkg::sew_e sew,
                             logic [DATA_W-1:0] d0, logic [DATA_W-1:0] d1, logic [7:0] be);
        logic [ADDR_W-1:0] addr;
        logic [31:0]       r;
        resp_t             x;
        addr = lcg_next();
        r    = lcg_next();
        drive(func_of(op), valu_pkg::OPIVV, op == valu_pkg::OP_MOVE, sew, d0, d1, be, addr,
              r[15:8], r[20], r[24]);
        x = '{cyc + 2, elem_model(op, sew, d0, d1, be), be, addr, r[15:8], r[20], r[24]};
        exp_q.push_back(x);
    endtask

    // three-beat group, one response two cycles after the end beat
    task automatic send_red(valu_pkg::valu_op_e op, valu_pkg::sew_e sew, logic [VL_W-1:0] vl);
        int                ew;
        int                idx;
        logic [DATA_W-1:0] m;
        logic [DATA_W-1:0] acc;
        logic [DATA_W-1:0] d0;
        logic [DATA_W-1:0] d1;
        logic [ADDR_W-1:0] addr;
        resp_t             x;
        ew  = 8 << int'(sew);
        m   = width_mask(ew);
        idx = 0;
        acc = '0;
        for (int b = 0; b < 3; b++) begin
            d0   = rand64();
            d1   = rand64();
            addr = lcg_next();
            if (b == 0) begin
                acc = d1 & m; // seed from element 0 of data1
            end
            for (int l = 0; l < DATA_W / ew; l++) begin
                if (idx < int'(vl)) begin
                    acc = fold(op, ew, acc, (d0 >> (l * ew)) & m);
                end
                idx++;
            end
            drive(func_of(op), valu_pkg::OPMVV, 1'b0, sew, d0, d1, 8'(lcg_next()), addr, vl,
                  b == 0, b == 2);
        end
        x = '{cyc + 2, acc, 8'((1 << (ew / 8)) - 1), addr, vl, 1'b1, 1'b1};
        exp_q.push_back(x);
        idle_beat();
    endtask

    task automatic test_idle();
        if (resp_valid !== 1'b0) begin
            abort("resp_valid is high right after reset");
        end
        check_flags(resp_start, resp_end, 1'b0, 1'b0, "after reset");
        repeat (20) @(posedge clk); // monitor flags any response here
    endtask

    task automatic test_logic();
        valu_pkg::valu_op_e ops[3];
        ops = '{valu_pkg::OP_AND, valu_pkg::OP_OR, valu_pkg::OP_XOR};
        for (int s = 0; s < 4; s++) begin
            for (int i = 0; i < 12; i++) begin
                send_elem(ops[i % 3], valu_pkg::sew_e'(s), rand64(), rand64(), 8'(lcg_next()));
            end
        end
        end_burst();
    endtask

    task automatic test_arith();
        valu_pkg::valu_op_e ops[6];
        logic [DATA_W-1:0]  edges[4];
        int                 ew;
        ops = '{valu_pkg::OP_ADD, valu_pkg::OP_SUB, valu_pkg::OP_MINU,
                valu_pkg::OP_MIN, valu_pkg::OP_MAXU, valu_pkg::OP_MAX};
        for (int s = 0; s < 4; s++) begin
            ew       = 8 << s;
            edges[0] = '0;
            edges[1] = '1;
            edges[2] = replicate(DATA_W'(1) << (ew - 1), ew); // most negative
            edges[3] = ~edges[2];
            for (int i = 0; i < 6; i++) begin
                for (int k = 0; k < 4; k++) begin
                    send_elem(ops[i], valu_pkg::sew_e'(s), edges[k], edges[(k + 1) % 4], 8'hff);
                end
                send_elem(ops[i], valu_pkg::sew_e'(s), rand64(), rand64(), 8'(lcg_next()));
                send_elem(ops[i], valu_pkg::sew_e'(s), rand64(), edges[2], 8'(lcg_next()));
            end
        end
        end_burst();
    endtask

    task automatic test_merge_move();
        for (int i = 0; i < 8; i++) begin
            send_elem(valu_pkg::OP_MERGE, valu_pkg::sew_e'(i % 4), rand64(), rand64(),
                      8'(lcg_next() >> 8));
        end
        for (int i = 0; i < 4; i++) begin
            send_elem(valu_pkg::OP_MOVE, valu_pkg::sew_e'(i), rand64(), rand64(), 8'(lcg_next()));
        end
        end_burst();
    endtask

    task automatic test_reduce();
        valu_pkg::valu_op_e ops[8];
        int                 per;
        ops = '{valu_pkg::OP_REDSUM, valu_pkg::OP_REDAND, valu_pkg::OP_REDOR,
                valu_pkg::OP_REDXOR, valu_pkg::OP_REDMINU, valu_pkg::OP_REDMIN,
                valu_pkg::OP_REDMAXU, valu_pkg::OP_REDMAX};
        for (int i = 0; i < 8; i++) begin
            for (int s = 0; s < 4; s++) begin
                per = 8 >> s;
                // vl lands inside the last beat, or drops it at SEW64
                send_red(ops[i], valu_pkg::sew_e'(s),
                         VL_W'((per == 1) ? 2 : 2 * per + 1 + int'(lcg_next() >> 8) % (per - 1)));
            end
        end
        end_burst();
    endtask

    task automatic test_unsupported();
        drive(6'b111111, valu_pkg::OPIVV, 1'b0, valu_pkg::SEW8, rand64(), rand64(), 8'hff,
              lcg_next(), 8'd4, 1'b1, 1'b1);
        drive(6'b001000, valu_pkg::OPMVV, 1'b0, valu_pkg::SEW16, rand64(), rand64(), 8'hff,
              lcg_next(), 8'd4, 1'b1, 1'b1);
        drive(6'b000000, 3'd5, 1'b0, valu_pkg::SEW32, rand64(), rand64(), 8'hff,
              lcg_next(), 8'd4, 1'b1, 1'b0);
        send_elem(valu_pkg::OP_ADD, valu_pkg::SEW8, rand64(), rand64(), 8'(lcg_next()));
        send_elem(valu_pkg::OP_XOR, valu_pkg::SEW32, rand64(), rand64(), 8'(lcg_next()));
        send_elem(valu_pkg::OP_MAX, valu_pkg::SEW16, rand64(), rand64(), 8'(lcg_next()));
        end_burst();
    endtask

    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (cyc >= MAX_CYCLES) begin
            abort($sformatf("timeout, run still going after %0d cycles", cyc));
        end
    end

    // outputs are settled at the falling edge
    always @(negedge clk) begin : monitor
        resp_t x;
        if (!rst && resp_valid) begin
            if (exp_q.size() == 0) begin
                abort("response arrived while none was expected");
            end else if (exp_q[0].cyc != cyc) begin
                abort($sformatf("response came in cycle %0d, expected in cycle %0d",
                                cyc, exp_q[0].cyc));
            end else begin
                x = exp_q.pop_front();
                check_data(resp_data, x.data);
                check_be(resp_be, x.be);
                check_flags(resp_start, resp_end, x.s, x.e, "response");
                check_tag(resp_addr, resp_vl, x.addr, x.vl);
            end
        end else if (!rst && exp_q.size() != 0 && exp_q[0].cyc <= cyc) begin
            abort("expected response did not arrive in time");
        end
    end

    initial begin
        req_valid   = 1'b0;
        req_op_mnr  = '0;
        req_func_id = '0;
        req_sew     = valu_pkg::SEW8;
        req_data0   = '0;
        req_data1   = '0;
        req_addr    = '0;
        req_be      = '0;
        req_vl      = '0;
        req_start   = 1'b0;
        req_end     = 1'b0;
        req_mask    = 1'b0;
        @(negedge rst);
        test_idle();
        test_logic();
        test_arith();
        test_merge_move();
        test_reduce();
        test_unsupported();
        if (exp_q.size() != 0) begin
            abort("responses still outstanding at end of run");
        end else begin
            $display("=== PASS ===");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* valu.f */
verilog/valu_pkg.sv
verilog/valu_decode.sv
verilog/valu_lane_ops.sv
verilog/valu_red_ctrl.sv
verilog/vbeat_counter.sv
verilog/valu_red_accum.sv
verilog/valu_top.sv
tb/valu_clkgen.sv
tb/valu_tb.sv

/* verilog/valu_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module valu_decode (
    input  wire logic [valu_pkg::FUNC_W-1:0] func_id,
    input  wire logic [valu_pkg::MNR_W-1:0]  op_mnr,
    input  wire logic                        mask,
    output valu_pkg::valu_op_e               op,
    output logic                             is_elem,
    output logic                             is_red
);

    always_comb begin
        op = valu_pkg::OP_NONE;
        if (op_mnr == valu_pkg::OPIVV) begin
            case (func_id)
                6'b000000: op = valu_pkg::OP_ADD;
                6'b000010: op = valu_pkg::OP_SUB;
                6'b000100: op = valu_pkg::OP_MINU;
                6'b000101: op = valu_pkg::OP_MIN;
                6'b000110: op = valu_pkg::OP_MAXU;
                6'b000111: op = valu_pkg::OP_MAX;
                6'b001001: op = valu_pkg::OP_AND;
                6'b001010: op = valu_pkg::OP_OR;
                6'b001011: op = valu_pkg::OP_XOR;
                6'b010111: op = mask ? valu_pkg::OP_MOVE : valu_pkg::OP_MERGE;
                default:   op = valu_pkg::OP_NONE;
            endcase
        end else if (op_mnr == valu_pkg::OPMVV) begin
            case (func_id)
                6'b000000: op = valu_pkg::OP_REDSUM;
                6'b000001: op = valu_pkg::OP_REDAND;
                6'b000010: op = valu_pkg::OP_REDOR;
                6'b000011: op = valu_pkg::OP_REDXOR;
                6'b000100: op = valu_pkg::OP_REDMINU;
                6'b000101: op = valu_pkg::OP_REDMIN;
                6'b000110: op = valu_pkg::OP_REDMAXU;
                6'b000111: op = valu_pkg::OP_REDMAX;
                default:   op = valu_pkg::OP_NONE;
            endcase
        end
    end

    // unit select follows enum order
    assign is_elem = op inside {[valu_pkg::OP_ADD:valu_pkg::OP_MOVE]};
    assign is_red  = op inside {[valu_pkg::OP_REDSUM:valu_pkg::OP_REDMAX]};

    always_comb begin
        assert (!(is_elem && is_red))
            else $error("decode selected both elementwise and reduction units");
    end

endmodule

`default_nettype wire

/* verilog/valu_lane_ops.sv */
`timescale 1ns/1ps
`default_nettype none

module valu_lane_ops #(
    parameter int DATA_W = 64
) (
    input  wire logic                clk,
    input  wire logic                rst,
    input  wire logic                valid,
    input  valu_pkg::valu_op_e       op,
    input  valu_pkg::sew_e           sew,
    input  wire logic [DATA_W-1:0]   data0,
    input  wire logic [DATA_W-1:0]   data1,
    input  wire logic [DATA_W/8-1:0] be,
    output logic                     out_valid,
    output logic [DATA_W-1:0]        out_data
);

    // operands arrive top-aligned so one function covers every element width
    function automatic logic [DATA_W-1:0] elem_fn(
        valu_pkg::valu_op_e f,
        logic [DATA_W-1:0] a,
        logic [DATA_W-1:0] b
    );
        case (f)
            valu_pkg::OP_ADD:  return a + b;
            valu_pkg::OP_SUB:  return a - b;
            valu_pkg::OP_MINU: return (a < b) ? a : b;
            valu_pkg::OP_MIN:  return ($signed(a) < $signed(b)) ? a : b;
            valu_pkg::OP_MAXU: return (a > b) ? a : b;
            valu_pkg::OP_MAX:  return ($signed(a) > $signed(b)) ? a : b;
            valu_pkg::OP_AND:  return a & b;
            valu_pkg::OP_OR:   return a | b;
            valu_pkg::OP_XOR:  return a ^ b;
            default:           return '0;
        endcase
    endfunction

    wire [DATA_W-1:0] sew_res [4]; // one result per element width
    logic [DATA_W-1:0] res;

    for (genvar g = 0; g < 4; g++) begin : g_sew
        localparam int EW = 8 << g;
        for (genvar l = 0; l < DATA_W / EW; l++) begin : g_lane
            wire [DATA_W-1:0] a_al;
            wire [DATA_W-1:0] b_al;
            wire [DATA_W-1:0] r_al;
            assign a_al = DATA_W'(data0[l*EW +: EW]) << (DATA_W - EW);
            assign b_al = DATA_W'(data1[l*EW +: EW]) << (DATA_W - EW);
            assign r_al = elem_fn(op, a_al, b_al);
            assign sew_res[g][l*EW +: EW] = r_al[DATA_W-1 -: EW];
        end
    end

    always_comb begin
        res = sew_res[sew];
        if (op == valu_pkg::OP_MERGE) begin
            for (int i = 0; i < DATA_W / 8; i++) begin
                res[i*8 +: 8] = be[i] ? data1[i*8 +: 8] : data0[i*8 +: 8];
            end
        end else if (op == valu_pkg::OP_MOVE) begin
            res = data0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= valid;
        end
    end

    always_ff @(posedge clk) begin
        if (valid) begin
            out_data <= res;
        end
    end

endmodule

`default_nettype wire

/* verilog/valu_pkg.sv */
`default_nettype none

package valu_pkg;

    localparam int FUNC_W = 6;
    localparam int MNR_W  = 3;
    localparam int SEW_W  = 2;

    // element width, 8 << code bits
    typedef enum logic [SEW_W-1:0] {
        SEW8  = 2'd0,
        SEW16 = 2'd1,
        SEW32 = 2'd2,
        SEW64 = 2'd3
    } sew_e;

    typedef enum logic [MNR_W-1:0] {
        OPIVV = 3'd0, // elementwise
        OPMVV = 3'd2  // reduction
    } opmnr_e;

    // elementwise ops first, then reductions; decode relies on this order
    typedef enum logic [4:0] {
        OP_NONE,
        OP_ADD,
        OP_SUB,
        OP_MINU,
        OP_MIN,
        OP_MAXU,
        OP_MAX,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_MERGE,
        OP_MOVE,
        OP_REDSUM,
        OP_REDAND,
        OP_REDOR,
        OP_REDXOR,
        OP_REDMINU,
        OP_REDMIN,
        OP_REDMAXU,
        OP_REDMAX
    } valu_op_e;

    typedef enum logic [1:0] {
        RED_IDLE,
        RED_ACCUM,
        RED_DONE
    } red_state_e;

endpackage

`default_nettype wire

/* verilog/valu_red_accum.sv */
`timescale 1ns/1ps
`default_nettype none

module valu_red_accum #(
    parameter int DATA_W = 64,
    parameter int VL_W   = 8
) (
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire logic              first_beat,
    input  wire logic              beat_en,
    input  valu_pkg::valu_op_e     op,
    input  valu_pkg::sew_e         sew,
    input  wire logic [DATA_W-1:0] data0,
    input  wire logic [DATA_W-1:0] data1,
    input  wire logic [VL_W-1:0]   vl,
    input  wire logic [15:0]       elem_base,
    input  wire logic              done,
    output logic                   out_valid,
    output logic [DATA_W-1:0]      out_data
);

    // accumulator is held top-aligned, low bits stay zero
    function automatic logic [DATA_W-1:0] red_fn(
        valu_pkg::valu_op_e f,
        logic [DATA_W-1:0] a,
        logic [DATA_W-1:0] b
    );
        case (f)
            valu_pkg::OP_REDSUM:  return a + b;
            valu_pkg::OP_REDAND:  return a & b;
            valu_pkg::OP_REDOR:   return a | b;
            valu_pkg::OP_REDXOR:  return a ^ b;
            valu_pkg::OP_REDMINU: return (a < b) ? a : b;
            valu_pkg::OP_REDMIN:  return ($signed(a) < $signed(b)) ? a : b;
            valu_pkg::OP_REDMAXU: return (a > b) ? a : b;
            valu_pkg::OP_REDMAX:  return ($signed(a) > $signed(b)) ? a : b;
            default:              return a;
        endcase
    endfunction

    logic [DATA_W-1:0] acc;
    logic [DATA_W-1:0] acc_nxt;
    valu_pkg::sew_e    acc_sew; // width of the group being folded

    always_comb begin
        int ew;
        int n;
        logic [DATA_W-1:0] hi_mask;
        logic [DATA_W-1:0] elem;
        ew      = 8 << sew;
        n       = DATA_W / ew;
        hi_mask = {DATA_W{1'b1}} << (DATA_W - ew);
        elem    = '0;
        acc_nxt = first_beat ? (data1 << (DATA_W - ew)) : acc; // seed from vs1[0]
        for (int l = 0; l < DATA_W / 8; l++) begin
            if (l < n && (int'(elem_base) + l) < int'(vl)) begin // past vl is dropped
                elem    = (data0 << (DATA_W - (l + 1) * ew)) & hi_mask;
                acc_nxt = red_fn(op, acc_nxt, elem);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (beat_en) begin
            acc <= acc_nxt;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            acc_sew <= valu_pkg::SEW8;
        end else if (beat_en) begin
            acc_sew <= sew;
        end
    end

    assign out_valid = done;
    assign out_data  = acc >> (DATA_W - (8 << acc_sew)); // element 0, upper lanes zero

endmodule

`default_nettype wire

/* verilog/valu_red_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module valu_red_ctrl (
    input  wire logic clk,
    input  wire logic rst,
    input  wire logic red_valid,
    input  wire logic start,
    input  wire logic end_beat,
    output logic      first_beat,
    output logic      beat_en,
    output logic      red_done
);

    valu_pkg::red_state_e state, state_nxt;

    always_comb begin
        state_nxt = state;
        case (state)
            valu_pkg::RED_IDLE: begin
                if (red_valid && start) begin
                    state_nxt = end_beat ? valu_pkg::RED_DONE : valu_pkg::RED_ACCUM;
                end
            end
            valu_pkg::RED_ACCUM: begin
                if (red_valid && end_beat) begin
                    state_nxt = valu_pkg::RED_DONE;
                end
            end
            valu_pkg::RED_DONE: begin
                // a new group may start right behind the previous one
                if (red_valid && start) begin
                    state_nxt = end_beat ? valu_pkg::RED_DONE : valu_pkg::RED_ACCUM;
                end else begin
                    state_nxt = valu_pkg::RED_IDLE;
                end
            end
            default: state_nxt = valu_pkg::RED_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= valu_pkg::RED_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    assign first_beat = red_valid & start;
    assign beat_en    = red_valid;
    assign red_done   = (state == valu_pkg::RED_DONE);

    // group framing from the requester
    a_idle_needs_start: assert property (@(posedge clk) disable iff (rst)
        (state == valu_pkg::RED_IDLE && red_valid) |-> start);
    a_no_restart_mid_group: assert property (@(posedge clk) disable iff (rst)
        (state == valu_pkg::RED_ACCUM && red_valid) |-> !start);

endmodule

`default_nettype wire

/* verilog/valu_top.sv */
`timescale 1ns/1ps
`default_nettype none

module valu_top #(
    parameter int DATA_W = 64,
    parameter int ADDR_W = 32,
    parameter int VL_W   = 8
) (
    input  wire logic                        clk,
    input  wire logic                        rst,
    input  wire logic                        req_valid,
    input  wire logic [valu_pkg::MNR_W-1:0]  req_op_mnr,
    input  wire logic [valu_pkg::FUNC_W-1:0] req_func_id,
    input  valu_pkg::sew_e                   req_sew,
    input  wire logic [DATA_W-1:0]           req_data0,
    input  wire logic [DATA_W-1:0]           req_data1,
    input  wire logic [ADDR_W-1:0]           req_addr,
    input  wire logic [DATA_W/8-1:0]         req_be,
    input  wire logic [VL_W-1:0]             req_vl,
    input  wire logic                        req_start,
    input  wire logic                        req_end,
    input  wire logic                        req_mask,
    output logic                             resp_valid,
    output logic                             resp_start,
    output logic                             resp_end,
    output logic [DATA_W-1:0]                resp_data,
    output logic [ADDR_W-1:0]                resp_addr,
    output logic [DATA_W/8-1:0]              resp_be,
    output logic [VL_W-1:0]                  resp_vl
);

    localparam int BE_W = DATA_W / 8;

    valu_pkg::valu_op_e op;
    logic               is_elem;
    logic               is_red;
    logic               first_beat;
    logic               beat_en;
    logic               red_done;
    logic [15:0]        elem_base;
    logic               lane_valid;
    logic [DATA_W-1:0]  lane_data;
    logic               red_valid;
    logic [DATA_W-1:0]  red_data;

    // sideband stage 1, lines up with the data modules
    logic [ADDR_W-1:0]  s1_addr;
    logic [VL_W-1:0]    s1_vl;
    logic [BE_W-1:0]    s1_be;
    valu_pkg::sew_e     s1_sew;
    logic               s1_start;
    logic               s1_end;
    logic [BE_W-1:0]    red_be;

    valu_decode u_decode (
        .func_id (req_func_id),
        .op_mnr  (req_op_mnr),
        .mask    (req_mask),
        .op      (op),
        .is_elem (is_elem),
        .is_red  (is_red)
    );

    valu_lane_ops #(
        .DATA_W (DATA_W)
    ) u_lane_ops (
        .clk       (clk),
        .rst       (rst),
        .valid     (req_valid & is_elem),
        .op        (op),
        .sew       (req_sew),
        .data0     (req_data0),
        .data1     (req_data1),
        .be        (req_be),
        .out_valid (lane_valid),
        .out_data  (lane_data)
    );

    valu_red_ctrl u_red_ctrl (
        .clk        (clk),
        .rst        (rst),
        .red_valid  (req_valid & is_red),
        .start      (req_start),
        .end_beat   (req_end),
        .first_beat (first_beat),
        .beat_en    (beat_en),
        .red_done   (red_done)
    );

    vbeat_counter #(
        .DATA_W (DATA_W)
    ) u_beat_cnt (
        .clk        (clk),
        .rst        (rst),
        .first_beat (first_beat),
        .beat_en    (beat_en),
        .sew        (req_sew),
        .elem_base  (elem_base)
    );

    valu_red_accum #(
        .DATA_W (DATA_W),
        .VL_W   (VL_W)
    ) u_red_accum (
        .clk        (clk),
        .rst        (rst),
        .first_beat (first_beat),
        .beat_en    (beat_en),
        .op         (op),
        .sew        (req_sew),
        .data0      (req_data0),
        .data1      (req_data1),
        .vl         (req_vl),
        .elem_base  (elem_base),
        .done       (red_done),
        .out_valid  (red_valid),
        .out_data   (red_data)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            s1_start <= 1'b0;
            s1_end   <= 1'b0;
        end else begin
            s1_start <= req_valid & req_start;
            s1_end   <= req_valid & req_end;
        end
    end

    always_ff @(posedge clk) begin
        s1_addr <= req_addr;
        s1_vl   <= req_vl;
        s1_be   <= req_be;
        s1_sew  <= req_sew;
    end

    assign red_be = BE_W'((1 << (1 << s1_sew)) - 1); // bytes of element 0

    always_ff @(posedge clk) begin
        if (rst) begin
            resp_valid <= 1'b0;
            resp_start <= 1'b0;
            resp_end   <= 1'b0;
        end else begin
            resp_valid <= lane_valid | red_valid;
            resp_start <= red_valid | s1_start;
            resp_end   <= red_valid | s1_end;
        end
    end

    always_ff @(posedge clk) begin
        resp_data <= red_valid ? red_data : lane_data;
        resp_be   <= red_valid ? red_be : s1_be;
        resp_addr <= s1_addr;
        resp_vl   <= s1_vl;
    end

    // reduction beats give no response of their own, so the paths never overlap
    a_one_source: assert property (@(posedge clk) disable iff (rst)
        !(lane_valid && red_valid));

endmodule

`default_nettype wire

/* verilog/vbeat_counter.sv */
`timescale 1ns/1ps
`default_nettype none

module vbeat_counter #(
    parameter int DATA_W = 64
) (
    input  wire logic      clk,
    input  wire logic      rst,
    input  wire logic      first_beat,
    input  wire logic      beat_en,
    input  valu_pkg::sew_e sew,
    output logic [15:0]    elem_base
);

    logic [15:0] cnt;
    logic [15:0] per_beat;

    assign per_beat  = 16'(DATA_W / 8) >> sew; // elements per beat
    assign elem_base = first_beat ? 16'd0 : cnt;

    always_ff @(posedge clk) begin
        if (rst) begin
            cnt <= '0;
        end else if (beat_en) begin
            cnt <= elem_base + per_beat;
        end
    end

endmodule

`default_nettype wire
